//--- project.f
+incdir+src
src/dcache_pkg.sv
src/dcache_ram.sv
src/dcache_meta.sv
src/dcache_lookup.sv
src/dcache_miss_ctrl.sv
src/dcache_top.sv
tests/dcache_axi_mem.sv
tests/dcache_assert.sv
tests/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f project.f

out=$(./obj_dir/Vdcache_tb)
echo "$out"

# status comes from the pass line
echo "$out" | grep -qx "sim passed"

//--- src/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// 64-byte lines, 64 sets, 32-bit words
`define DC_LINE_BITS  6
`define DC_INDEX_BITS 6
`define DC_WORD_BITS  4
`define DC_NR_WORDS   16  // also the AXI burst length
`define DC_TAG_BITS   20

`endif

//--- src/dcache_lookup.sv
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  mem_req_t     req,
    input  tag_t   [1:0] way_tag,
    input  word_t  [1:0] way_data,
    input  logic   [1:0] valid,
    input  logic         active,
    output logic         hit,
    output logic         hit_way,
    output word_t        hit_data,
    output wmask_t [1:0] data_wr_en
);
    tag_t         req_tag;
    ram_addr_t    req_word;
    logic   [1:0] way_match;
    word_t  [1:0] fwd_data;
    ram_addr_t    last_addr;
    word_t        last_data;
    word_t  [1:0] last_mask;  // bit mask of the last store, per way

    function automatic word_t expand_mask(wmask_t m);
        word_t bits;
        for (int i = 0; i < 4; i++) begin
            bits[i*8 +: 8] = {8{m[i]}};
        end
        return bits;
    endfunction

    assign req_tag  = req.addr[31 -: `DC_TAG_BITS];
    assign req_word = req.addr[`DC_LINE_BITS+`DC_INDEX_BITS-1:2];

    for (genvar g = 0; g < 2; g++) begin : g_way
        assign way_match[g] = valid[g] && (way_tag[g] == req_tag);
        // RAM output misses a store made in the previous cycle
        assign fwd_data[g] = (last_addr == req_word)
                           ? (last_data & last_mask[g]) | (way_data[g] & ~last_mask[g])
                           : way_data[g];
        assign data_wr_en[g] = (active && req.en && req.write && way_match[g])
                             ? req.mask : '0;
    end

    assign hit      = |way_match;
    assign hit_way  = way_match[1];
    assign hit_data = fwd_data[hit_way];

    always_ff @(posedge clk) begin
        last_addr <= req_word;
        last_data <= req.wdata;
        if (rst) begin
            last_mask <= '0;
        end else begin
            last_mask[0] <= expand_mask(data_wr_en[0]);
            last_mask[1] <= expand_mask(data_wr_en[1]);
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_meta.sv
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_meta
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  index_t     lookup_index,
    output logic [1:0] valid,
    output logic [1:0] dirty,
    output logic       lru_way,
    input  logic       touch,
    input  logic       touch_way,
    input  logic       set_dirty,
    input  logic       clean,
    input  logic       fill,
    input  logic       fill_way
);
    localparam int NR_SETS = 1 << `DC_INDEX_BITS;

    logic [NR_SETS-1:0][1:0] valid_q;
    logic [NR_SETS-1:0][1:0] dirty_q;
    logic [NR_SETS-1:0]      lru_q;    // way to evict next

    assign valid   = valid_q[lookup_index];
    assign dirty   = dirty_q[lookup_index];
    assign lru_way = lru_q[lookup_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (touch) begin
                lru_q[lookup_index] <= !touch_way;
                if (set_dirty) begin
                    dirty_q[lookup_index][touch_way] <= 1'b1;
                end
            end
            if (clean) begin
                dirty_q[lookup_index][fill_way] <= 1'b0;  // victim written back
            end
            if (fill) begin
                valid_q[lookup_index][fill_way] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_miss_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  mem_req_t     req,
    input  logic         hit,
    input  word_t        hit_data,
    input  logic         stall_m,
    input  logic         lru_way,
    input  logic         victim_dirty,
    input  tag_t   [1:0] victim_tag,
    input  word_t  [1:0] way_data,
    output cache_state_e state,
    output logic         dstall,
    output word_t        rdata_saved,
    output ram_addr_t    ram_rd_addr,
    output wmask_t [1:0] fill_wr_en,
    output ram_addr_t    fill_addr,
    output logic   [1:0] tag_wr_en,
    output tag_t         fill_tag,
    output logic         touch,
    output logic         set_dirty,
    output logic         clean,
    output logic         fill,
    output logic         fill_way,
    output axi_ar_t      ar,
    output logic         arvalid,
    input  logic         arready,
    input  axi_r_t       r,
    input  logic         rvalid,
    output logic         rready,
    output axi_aw_t      aw,
    output logic         awvalid,
    input  logic         awready,
    output axi_w_t       w,
    output logic         wvalid,
    input  logic         wready,
    input  logic         bvalid
);
    cache_state_e          state_d;
    index_t                req_index;
    logic                  miss;
    logic                  vway;       // victim way, fixed for the whole miss
    logic                  b_pending;  // write response still owed
    logic [`DC_WORD_BITS:0] rd_cnt;    // victim words issued to the RAM
    logic                  out_ok;     // RAM output holds an unsent word
    logic                  load_w;
    logic                  advance;
    word_off_t             wb_word;
    logic                  wb_done;
    logic                  start_refill;
    logic                  fill_beat;
    word_off_t             fill_cnt;
    logic                  r_done;
    logic                  refill_end;

    assign req_index = req.addr[`DC_LINE_BITS +: `DC_INDEX_BITS];
    assign miss      = (state == s_idle) && req.en && !hit;

    always_comb begin
        state_d = state;
        case (state)
            s_idle: begin
                if (miss) begin
                    state_d = victim_dirty ? s_writeback : s_refill;
                end else if (req.en && stall_m) begin
                    state_d = s_hold;
                end
            end
            s_writeback: if (wb_done) state_d = s_refill;
            s_refill:    if (refill_end) state_d = s_idle;
            s_hold:      if (!stall_m) state_d = s_idle;
            default:     state_d = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_d;
        end
    end

    assign start_refill = (state_d == s_refill) && (state != s_refill);

    // victim snapshot and AW channel
    always_ff @(posedge clk) begin
        if (rst) begin
            vway      <= 1'b0;
            b_pending <= 1'b0;
            awvalid   <= 1'b0;
        end else if (miss) begin
            vway      <= lru_way;
            b_pending <= victim_dirty;
            awvalid   <= victim_dirty;
        end else begin
            if (awvalid && awready) awvalid <= 1'b0;
            if (clean) b_pending <= 1'b0;
        end
    end

    // writeback read-ahead, one RAM read in front of W
    assign load_w  = out_ok && (!wvalid || wready);
    assign advance = !out_ok || load_w;
    assign wb_word = advance ? rd_cnt[`DC_WORD_BITS-1:0] : rd_cnt[`DC_WORD_BITS-1:0] - 1'b1;
    assign wb_done = wvalid && wready && w.wlast;

    always_ff @(posedge clk) begin
        if (rst || state != s_writeback) begin
            rd_cnt <= '0;
            out_ok <= 1'b0;
        end else if (advance) begin
            out_ok <= !rd_cnt[`DC_WORD_BITS];
            if (!rd_cnt[`DC_WORD_BITS]) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wvalid <= 1'b0;
        end else if (load_w) begin
            wvalid <= 1'b1;
        end else if (wready) begin
            wvalid <= 1'b0;
        end
    end

    // refill over AR/R
    assign fill_beat  = rvalid && rready;
    assign refill_end = (state == s_refill) && r_done && !b_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            r_done   <= 1'b0;
            fill_cnt <= '0;
        end else if (start_refill) begin
            arvalid  <= 1'b1;
            rready   <= 1'b1;
            r_done   <= 1'b0;
            fill_cnt <= '0;
        end else begin
            if (arvalid && arready) arvalid <= 1'b0;
            if (fill_beat) begin
                fill_cnt <= fill_cnt + 1'b1;
                if (r.rlast) begin
                    rready <= 1'b0;
                    r_done <= 1'b1;  // one more cycle lets the RAM re-read m_req
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            aw.awaddr <= {victim_tag[lru_way], req_index, {`DC_LINE_BITS{1'b0}}};
            aw.awlen  <= 8'(`DC_NR_WORDS - 1);
        end
        if (start_refill) begin
            ar.araddr <= {req.addr[31:`DC_LINE_BITS], {`DC_LINE_BITS{1'b0}}};
            ar.arlen  <= 8'(`DC_NR_WORDS - 1);
        end
        if (load_w) begin
            w.wdata <= way_data[vway];
            w.wlast <= rd_cnt[`DC_WORD_BITS];  // all 16 reads issued
        end
        if (state == s_idle && state_d == s_hold) begin
            rdata_saved <= hit_data;
        end
    end

    assign dstall = (state == s_idle) ? (req.en && !hit) : (state != s_hold);

    assign ram_rd_addr = (state == s_writeback) ? {req_index, wb_word}
                       : req.addr[`DC_LINE_BITS+`DC_INDEX_BITS-1:2];
    assign fill_addr   = {req_index, fill_cnt};
    assign fill_tag    = req.addr[31 -: `DC_TAG_BITS];
    assign tag_wr_en   = {vway, !vway} & {2{arvalid && arready}};  // new tag on AR accept
    assign fill_wr_en[0] = (fill_beat && !vway) ? '1 : '0;
    assign fill_wr_en[1] = (fill_beat && vway) ? '1 : '0;

    assign touch     = (state == s_idle) && req.en && hit;
    assign set_dirty = touch && req.write;
    assign clean     = b_pending && bvalid;
    assign fill      = refill_end;
    assign fill_way  = vway;

endmodule

`default_nettype wire

//--- src/dcache_pkg.sv
`default_nettype none
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wmask_t;
    typedef logic [`DC_TAG_BITS-1:0]                 tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]               index_t;
    typedef logic [`DC_WORD_BITS-1:0]                word_off_t;
    typedef logic [`DC_INDEX_BITS+`DC_WORD_BITS-1:0] ram_addr_t;  // {set, word}

    // memory-stage access from the core
    typedef struct packed {
        logic   en;
        logic   write;
        wmask_t mask;
        paddr_t addr;
        word_t  wdata;
    } mem_req_t;

    typedef struct packed {
        paddr_t     araddr;
        logic [7:0] arlen;
    } axi_ar_t;

    typedef struct packed {
        word_t rdata;
        logic  rlast;
    } axi_r_t;

    typedef struct packed {
        paddr_t     awaddr;
        logic [7:0] awlen;
    } axi_aw_t;

    typedef struct packed {
        word_t wdata;
        logic  wlast;
    } axi_w_t;

    typedef enum logic [1:0] {
        s_idle,
        s_writeback,
        s_refill,
        s_hold
    } cache_state_e;

endpackage

`default_nettype wire

//--- src/dcache_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_ram #(
    parameter int DATA_BITS  = 32,
    parameter int ADDR_BITS  = 10,
    parameter bit BYTE_WRITE = 1'b1
) (
    input  logic                                       clk,
    input  logic [(BYTE_WRITE ? DATA_BITS/8 : 1)-1:0] wr_en,
    input  logic [ADDR_BITS-1:0]                       wr_addr,
    input  logic [DATA_BITS-1:0]                       wr_data,
    input  logic [ADDR_BITS-1:0]                       rd_addr,
    output logic [DATA_BITS-1:0]                       rd_data
);
    localparam int NR_LANES  = BYTE_WRITE ? DATA_BITS / 8 : 1;
    localparam int LANE_BITS = DATA_BITS / NR_LANES;

    logic [DATA_BITS-1:0] mem [1 << ADDR_BITS];

    always_ff @(posedge clk) begin
        for (int i = 0; i < NR_LANES; i++) begin
            if (wr_en[i]) begin
                mem[wr_addr][i*LANE_BITS +: LANE_BITS] <= wr_data[i*LANE_BITS +: LANE_BITS];
            end
        end
        rd_data <= mem[rd_addr];  // old data on a same-address write
    end

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  paddr_t   e_addr,   // next access, one stage early
    input  mem_req_t m_req,
    input  logic     stall_m,
    output logic     dstall,
    output word_t    rdata,
    output axi_ar_t  ar,
    output logic     arvalid,
    input  logic     arready,
    input  axi_r_t   r,
    input  logic     rvalid,
    output logic     rready,
    output axi_aw_t  aw,
    output logic     awvalid,
    input  logic     awready,
    output axi_w_t   w,
    output logic     wvalid,
    input  logic     wready,
    input  logic     bvalid
);
    cache_state_e state;
    tag_t   [1:0] way_tag;
    word_t  [1:0] way_data;
    logic   [1:0] valid;
    logic   [1:0] dirty;
    logic         lru_way;
    logic         victim_dirty;
    logic         active;
    logic         refilling;
    logic         hit;
    logic         hit_way;
    word_t        hit_data;
    word_t        rdata_saved;
    wmask_t [1:0] data_wr_en;
    wmask_t [1:0] fill_wr_en;
    wmask_t [1:0] ram_wr_en;
    logic   [1:0] tag_wr_en;
    tag_t         fill_tag;
    ram_addr_t    ram_rd_addr;
    ram_addr_t    fill_addr;
    ram_addr_t    rd_addr;
    ram_addr_t    wr_addr;
    word_t        wr_data;
    logic         touch;
    logic         set_dirty;
    logic         clean;
    logic         fill;
    logic         fill_way;

    assign active    = (state == s_idle);
    assign refilling = (state == s_refill);

    // controller owns the read port while a miss is in flight
    assign rd_addr = (state == s_writeback || refilling) ? ram_rd_addr
                   : e_addr[`DC_LINE_BITS+`DC_INDEX_BITS-1:2];
    assign wr_addr   = refilling ? fill_addr : m_req.addr[`DC_LINE_BITS+`DC_INDEX_BITS-1:2];
    assign wr_data   = refilling ? r.rdata : m_req.wdata;
    assign ram_wr_en = data_wr_en | fill_wr_en;  // never both at once

    assign victim_dirty = dirty[lru_way];
    assign rdata = (state == s_hold) ? rdata_saved : hit_data;

    for (genvar g = 0; g < 2; g++) begin : g_way
        dcache_ram #(
            .DATA_BITS (32),
            .ADDR_BITS (`DC_INDEX_BITS + `DC_WORD_BITS),
            .BYTE_WRITE(1'b1)
        ) u_data (
            .clk    (clk),
            .wr_en  (ram_wr_en[g]),
            .wr_addr(wr_addr),
            .wr_data(wr_data),
            .rd_addr(rd_addr),
            .rd_data(way_data[g])
        );

        dcache_ram #(
            .DATA_BITS (`DC_TAG_BITS),
            .ADDR_BITS (`DC_INDEX_BITS),
            .BYTE_WRITE(1'b0)
        ) u_tag (
            .clk    (clk),
            .wr_en  (tag_wr_en[g]),
            .wr_addr(fill_addr[`DC_WORD_BITS +: `DC_INDEX_BITS]),
            .wr_data(fill_tag),
            .rd_addr(rd_addr[`DC_WORD_BITS +: `DC_INDEX_BITS]),
            .rd_data(way_tag[g])
        );
    end

    dcache_meta u_meta (
        .*,
        .lookup_index(m_req.addr[`DC_LINE_BITS +: `DC_INDEX_BITS]),
        .touch_way   (hit_way)
    );

    dcache_lookup u_lookup (
        .*,
        .req(m_req)
    );

    dcache_miss_ctrl u_ctrl (
        .*,
        .req       (m_req),
        .victim_tag(way_tag)
    );

endmodule

`default_nettype wire

//--- tests/dcache_assert.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_assert
    import dcache_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   arvalid,
    input logic   arready,
    input logic   awvalid,
    input logic   awready,
    input logic   wvalid,
    input logic   wready,
    input axi_w_t w,
    input logic   dstall
);
    logic [4:0] beats;  // W beats accepted in the current burst

    always_ff @(posedge clk) begin
        if (rst) begin
            beats <= '0;
        end else if (wvalid && wready) begin
            beats <= w.wlast ? 5'd0 : beats + 5'd1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    // wlast exactly on beat 16
    wlast_pos: assert property (@(posedge clk) disable iff (rst)
        wvalid && wready |-> (w.wlast == (beats == 5'd15)))
        else $error("wlast not on the 16th beat");

    reset_stall: assert property (@(posedge clk) $fell(rst) |-> !dstall)
        else $error("dstall high right after reset");

endmodule

`default_nettype wire

//--- tests/dcache_axi_mem.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_axi_mem
    import dcache_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h4b12_fd21
) (
    input  logic    clk,
    input  logic    rst,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output logic    bvalid
);
    word_t       mem [paddr_t];  // only words that were written back
    logic [31:0] rnd;
    paddr_t      rd_base;
    paddr_t      wr_base;
    logic [3:0]  rd_cnt;
    logic [3:0]  wr_cnt;
    logic        rd_busy;
    logic        aw_got;  // W beats are taken only after the address

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t read_word(paddr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a_0000;  // untouched memory
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rnd     <= SEED;
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            r       <= '0;
            rd_busy <= 1'b0;
            aw_got  <= 1'b0;
            rd_cnt  <= '0;
            wr_cnt  <= '0;
        end else begin
            rnd     <= lcg_next(rnd);
            bvalid  <= 1'b0;
            // random ready delays from the upper LCG bits
            arready <= !rd_busy && !(arvalid && arready) && rnd[31];
            awready <= !aw_got && !(awvalid && awready) && rnd[29];
            wready  <= aw_got && !(wvalid && wready && w.wlast) && rnd[28];

            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_base <= ar.araddr;
                rd_cnt  <= '0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rd_cnt <= rd_cnt + 4'd1;
                if (r.rlast) begin
                    rd_busy <= 1'b0;
                end
            end else if (rd_busy && !rvalid && rnd[30]) begin
                rvalid  <= 1'b1;
                r.rdata <= read_word({rd_base[31:6], rd_cnt, 2'b00});
                r.rlast <= (rd_cnt == 4'd15);
            end

            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                wr_base <= aw.awaddr;
                wr_cnt  <= '0;
            end
            if (wvalid && wready) begin
                mem[{wr_base[31:6], wr_cnt, 2'b00}] = w.wdata;
                wr_cnt <= wr_cnt + 4'd1;
                if (w.wlast) begin
                    aw_got <= 1'b0;
                    bvalid <= 1'b1;  // one-cycle write response
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
;
    localparam paddr_t     LINE_A    = 32'h0001_0040;  // set 1
    localparam int         NR_BEATS  = 6 * 16;         // five refills, one writeback
    localparam int         TIMEOUT   = NR_BEATS * 50 + 500;
    localparam logic [7:0] BURST_LEN = 8'd15;          // 16 beats per line

    logic     clk;
    logic     rst;
    paddr_t   e_addr;
    mem_req_t m_req;
    logic     stall_m;
    logic     dstall;
    word_t    rdata;
    axi_ar_t  ar;
    logic     arvalid;
    logic     arready;
    axi_r_t   r;
    logic     rvalid;
    logic     rready;
    axi_aw_t  aw;
    logic     awvalid;
    logic     awready;
    axi_w_t   w;
    logic     wvalid;
    logic     wready;
    logic     bvalid;

    word_t    ref_mem [paddr_t];  // expected memory image, written words only
    word_t    wb_q [$];           // every W beat seen
    axi_ar_t  ar_seen;            // last accepted read burst
    axi_aw_t  aw_seen;
    word_t    got;
    logic     first_stall;
    int       checks = 0;
    int       errors = 0;
    int       cycles = 0;

    dcache_top uut (.*);
    dcache_axi_mem mem_model (.*);

    bind dcache_top dcache_assert u_assert (
        .clk    (clk),
        .rst    (rst),
        .arvalid(arvalid),
        .arready(arready),
        .awvalid(awvalid),
        .awready(awready),
        .wvalid (wvalid),
        .wready (wready),
        .w      (w),
        .dstall (dstall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, cache never finished", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // bus monitor
    always @(posedge clk) begin
        if (arvalid && arready) ar_seen <= ar;
        if (awvalid && awready) aw_seen <= aw;
        if (wvalid && wready) wb_q.push_back(w.wdata);
    end

    function automatic word_t merge_bytes(word_t old, word_t data, wmask_t m);
        word_t res;
        for (int i = 0; i < 4; i++) begin
            res[i*8 +: 8] = m[i] ? data[i*8 +: 8] : old[i*8 +: 8];
        end
        return res;
    endfunction

    function automatic word_t expected_word(paddr_t a);
        paddr_t wa;
        wa = {a[31:2], 2'b00};
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return wa ^ 32'h5a5a_0000;
    endfunction

    function automatic mem_req_t load_req(paddr_t a);
        mem_req_t q;
        q      = '0;
        q.en   = 1'b1;
        q.addr = a;
        return q;
    endfunction

    function automatic mem_req_t store_req(paddr_t a, wmask_t m, word_t d);
        mem_req_t q;
        q       = load_req(a);
        q.write = 1'b1;
        q.mask  = m;
        q.wdata = d;
        return q;
    endfunction

    task automatic store_ref(input paddr_t a, input wmask_t m, input word_t d);
        paddr_t wa;
        wa = {a[31:2], 2'b00};
        ref_mem[wa] = merge_bytes(expected_word(wa), d, m);
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, act, exp);
        end
    endtask

    task automatic check_addr(input string name, input paddr_t act, input paddr_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_len(input string name, input logic [7:0] act, input logic [7:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, act, exp);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "errors");
    endtask

    // idle cycle so the RAMs read addr one stage early
    task automatic prime(input paddr_t addr);
        @(posedge clk);
        m_req  <= '0;
        e_addr <= addr;
    endtask

    task automatic access(input mem_req_t req, input paddr_t next_addr);
        @(posedge clk);
        m_req  <= req;
        e_addr <= next_addr;
        @(negedge clk);
        first_stall = dstall;
        while (dstall) begin
            @(negedge clk);
        end
        got = rdata;
    endtask

    task automatic read_miss();
        paddr_t a;
        int     errs;
        errs = errors;
        a = LINE_A + 32'h8;
        prime(a);
        access(load_req(a), a);
        check_bit("dstall", first_stall, 1'b1);
        check_word("rdata", got, expected_word(a));
        check_addr("araddr", ar_seen.araddr, {a[31:6], 6'b0});
        check_len("arlen", ar_seen.arlen, BURST_LEN);
        report_test(1, "read miss", errs);
    endtask

    task automatic line_hits();
        paddr_t a;
        int     errs;
        errs = errors;
        prime(LINE_A);
        for (int i = 0; i < 16; i++) begin
            a = LINE_A + 32'(4 * i);
            access(load_req(a), a + 32'h4);
            check_bit("dstall", first_stall, 1'b0);
            check_word("rdata", got, expected_word(a));
        end
        report_test(2, "line hits", errs);
    endtask

    task automatic store_forward();
        paddr_t a;
        int     errs;
        errs = errors;
        a = LINE_A + 32'h10;
        prime(a);
        access(store_req(a, 4'b0101, 32'h1122_3344), a);
        store_ref(a, 4'b0101, 32'h1122_3344);
        check_bit("dstall", first_stall, 1'b0);
        access(load_req(a), a);  // back to back with the store
        check_bit("dstall", first_stall, 1'b0);
        check_word("rdata", got, expected_word(a));
        report_test(3, "store forward", errs);
    endtask

    task automatic lru_eviction();
        paddr_t a;
        paddr_t b;
        paddr_t c;
        int     errs;
        int     start;
        errs = errors;
        a = 32'h0002_0140;  // three lines of set 5
        b = 32'h0003_0140;
        c = 32'h0004_0140;
        prime(a);
        access(load_req(a), b + 32'h20);
        check_word("rdata", got, expected_word(a));
        access(store_req(b + 32'h20, 4'b1111, 32'hcafe_0001), b + 32'h24);
        store_ref(b + 32'h20, 4'b1111, 32'hcafe_0001);
        access(store_req(b + 32'h24, 4'b1000, 32'h7700_0000), a);
        store_ref(b + 32'h24, 4'b1000, 32'h7700_0000);
        check_bit("dstall", first_stall, 1'b0);
        access(load_req(a), c + 32'h4);  // A most recent, B is LRU
        check_bit("dstall", first_stall, 1'b0);
        start = wb_q.size();
        access(load_req(c + 32'h4), a);
        check_bit("dstall", first_stall, 1'b1);
        check_word("rdata", got, expected_word(c + 32'h4));
        check_addr("awaddr", aw_seen.awaddr, b);
        check_len("awlen", aw_seen.awlen, BURST_LEN);
        check_addr("araddr", ar_seen.araddr, c);
        check_len("arlen", ar_seen.arlen, BURST_LEN);
        if (wb_q.size() - start != 16) begin
            errors++;
            $display("writeback of B carried %0d beats instead of 16", wb_q.size() - start);
        end else begin
            for (int i = 0; i < 16; i++) begin
                check_word("wdata", wb_q[start + i], expected_word(b + 32'(4 * i)));
            end
        end
        access(load_req(a), b + 32'h20);  // A must have survived
        check_bit("dstall", first_stall, 1'b0);
        check_word("rdata", got, expected_word(a));
        access(load_req(b + 32'h20), b + 32'h24);
        check_bit("dstall", first_stall, 1'b1);
        check_word("rdata", got, expected_word(b + 32'h20));
        access(load_req(b + 32'h24), b + 32'h24);
        check_bit("dstall", first_stall, 1'b0);
        check_word("rdata", got, expected_word(b + 32'h24));
        report_test(4, "lru eviction", errs);
    endtask

    task automatic stall_hold();
        paddr_t a;
        paddr_t b;
        int     errs;
        errs = errors;
        a = LINE_A + 32'h24;
        b = LINE_A + 32'h30;
        prime(a);
        @(posedge clk);
        m_req   <= load_req(a);
        e_addr  <= b;
        stall_m <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_bit("dstall", dstall, 1'b0);
            check_word("rdata", rdata, expected_word(a));
        end
        @(posedge clk);
        stall_m <= 1'b0;
        @(negedge clk);
        check_bit("dstall", dstall, 1'b0);
        check_word("rdata", rdata, expected_word(a));
        access(load_req(b), b);
        check_bit("dstall", first_stall, 1'b0);
        check_word("rdata", got, expected_word(b));
        report_test(5, "stall hold", errs);
    endtask

    initial begin
        rst     <= 1'b1;
        e_addr  <= '0;
        m_req   <= '0;
        stall_m <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        read_miss();
        line_hits();
        store_forward();
        lru_eviction();
        stall_hold();
        @(posedge clk);
        m_req <= '0;
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
